//--- Makefile
TOP       ?= tb_uart_top
VERILATOR ?= verilator
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --timing --assert
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the pass line in the simulator output
run: build
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '=== PASS ==='

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_uart_top.sv
`include "uart_defines.svh"

module tb_uart_top;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_pkg::*;

    localparam int BIT_CLKS   = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int FRAME_CLKS = 11 * BIT_CLKS;
    localparam int NUM_TESTS  = 17;
    localparam int WD_CLKS    = 3 * NUM_TESTS * 2 * FRAME_CLKS;
    localparam bit PARITY_ON  = (`UART_PARITY != 0);
    localparam bit PARITY_ODD = (`UART_PARITY == 2);

    typedef enum logic [2:0] {
        M_LOOP, M_BAD_PAR, M_BAD_STOP, M_GLITCH, M_OVERRUN, M_TX_PAIR
    } mode_e;

    typedef struct packed {
        logic [7:0] data;
        logic [7:0] data2;    // Second byte of a pair
        mode_e      mode;
        rx_word_t   exp;
    } test_t;

    logic       clk;
    logic       rst;
    logic       tx_req;
    logic [7:0] tx_data;
    logic       tx_ack;
    logic       rx_req;
    rx_word_t   rx_word;
    logic       rx_ack;
    logic       txd;
    logic       rxd;
    logic       loop_sel;
    logic       gen_line;
    test_t      tests [NUM_TESTS];
    int         seed = 83;
    int         errs;

    assign rxd = loop_sel ? txd : gen_line;

    uart_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WD_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks", WD_CLKS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic wait_clk(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic drive_line(input logic b, input int clks);
        gen_line = b;
        wait_clk(clks);
    endtask

    task automatic send_frame(input logic [7:0] data, input bit bad_par, input bit bad_stop);
        int k;
        drive_line(1'b0, BIT_CLKS);
        for (k = 0; k < 8; k++) begin
            drive_line(data[k], BIT_CLKS);    // LSB first
        end
        if (PARITY_ON) begin
            drive_line(^data ^ PARITY_ODD ^ bad_par, BIT_CLKS);
        end
        drive_line(!bad_stop, BIT_CLKS);
        gen_line = 1'b1;
    endtask

    // low_seen tells whether a start bit went out while waiting for the ack
    task automatic send_byte(input logic [7:0] data, output bit low_seen);
        int n;
        tx_data  = data;
        tx_req   = 1'b1;
        low_seen = 1'b0;
        for (n = 0; n < 2 * FRAME_CLKS && !tx_ack; n++) begin
            wait_clk(1);
            low_seen |= !txd;
        end
        assert (tx_ack) else begin
            $display("tx_ack never rose for byte %h", data);
            errs++;
        end
        tx_req = 1'b0;
        wait_clk(2);
    endtask

    task automatic get_word(input int max_clks, output rx_word_t w, output bit got);
        int n;
        for (n = 0; n < max_clks && !rx_req; n++) begin
            wait_clk(1);
        end
        got = rx_req;
        w   = rx_word;
        if (got) begin
            rx_ack = 1'b1;
            for (n = 0; n < 8 && rx_req; n++) begin
                wait_clk(1);
            end
            rx_ack = 1'b0;
            wait_clk(1);
        end
    endtask

    task automatic check_word(input rx_word_t exp);
        rx_word_t w;
        bit       got;
        get_word(2 * FRAME_CLKS, w, got);
        assert (got) else begin
            $display("No word arrived on rx_req, expected data %h", exp.data);
            errs++;
        end
        assert (!got || w == exp) else begin
            $display("Error: rx_word expected %h received %h", exp, w);
            errs++;
        end
    endtask

    task automatic check_quiet();
        rx_word_t w;
        bit       got;
        get_word(FRAME_CLKS, w, got);
        assert (!got) else begin
            $display("An extra word arrived on rx_req with data %h", w.data);
            errs++;
        end
    endtask

    function automatic test_t make_test(input logic [7:0] d, input logic [7:0] d2, input mode_e m);
        test_t t;
        t.data           = d;
        t.data2          = d2;
        t.mode           = m;
        t.exp.data       = d;
        t.exp.parity_err = PARITY_ON && (m == M_BAD_PAR);
        t.exp.frame_err  = (m == M_BAD_STOP);
        t.exp.overrun    = (m == M_OVERRUN);    // First word of the pair survives
        return t;
    endfunction

    initial begin
        test_t       t;
        test_t       t2;
        mode_e       m;
        logic [31:0] rnd;
        bit          low_seen;
        int          i;
        int          errs_before;
        int          failed;
        rst      = 1'b1;
        tx_req   = 1'b0;
        tx_data  = '0;
        rx_ack   = 1'b0;
        loop_sel = 1'b1;
        gen_line = 1'b1;
        errs     = 0;
        failed   = 0;
        tests[0] = make_test(8'h00, 8'h00, M_LOOP);
        tests[1] = make_test(8'hFF, 8'h00, M_LOOP);
        tests[2] = make_test(8'hA5, 8'h00, M_LOOP);
        tests[3] = make_test(8'h5A, 8'h00, M_LOOP);
        tests[4] = make_test(8'hC3, 8'h00, M_BAD_PAR);
        tests[5] = make_test(8'h3C, 8'h00, M_BAD_STOP);
        tests[6] = make_test(8'h96, 8'h00, M_GLITCH);
        tests[7] = make_test(8'h81, 8'h7E, M_OVERRUN);
        for (i = 8; i < 16; i++) begin
            rnd      = $random(seed);
            tests[i] = make_test(rnd[7:0], 8'h00, M_LOOP);
        end
        tests[16] = make_test(8'h3C, 8'hC3, M_TX_PAIR);
        wait_clk(3);
        rst = 1'b0;

        for (i = 0; i < NUM_TESTS; i++) begin
            t           = tests[i];
            m           = t.mode;
            errs_before = errs;
            loop_sel    = (m == M_LOOP || m == M_TX_PAIR);
            wait_clk(1);
            case (m)
                M_LOOP: begin
                    send_byte(t.data, low_seen);
                    check_word(t.exp);
                end
                M_TX_PAIR: begin
                    send_byte(t.data, low_seen);
                    send_byte(t.data2, low_seen);
                    assert (low_seen) else begin
                        $display("Second tx_ack came before the first byte was taken");
                        errs++;
                    end
                    t2 = make_test(t.data2, 8'h00, M_LOOP);
                    check_word(t.exp);
                    check_word(t2.exp);
                end
                M_GLITCH: begin
                    drive_line(1'b0, BIT_CLKS / 4);    // Quarter bit low
                    drive_line(1'b1, BIT_CLKS);
                    send_frame(t.data, 1'b0, 1'b0);
                    check_word(t.exp);
                    check_quiet();
                end
                M_OVERRUN: begin
                    send_frame(t.data, 1'b0, 1'b0);    // No ack yet
                    send_frame(t.data2, 1'b0, 1'b0);
                    check_word(t.exp);
                    check_quiet();
                end
                default: begin
                    send_frame(t.data, m == M_BAD_PAR, m == M_BAD_STOP);
                    check_word(t.exp);
                end
            endcase
            if (errs != errs_before) begin
                failed++;
            end
            $display("Test %0d %s data %h: %s", i, m.name(), t.data,
                     (errs == errs_before) ? "ok" : "failed");
        end

        $display("Tests %0d, failed %0d, check errors %0d", NUM_TESTS, failed, errs);
        if (errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hw/uart_baud_gen.sv
`include "uart_defines.svh"

module uart_baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int unsigned DIV   = `UART_CLK_FREQ / (`UART_BAUD_RATE * `UART_OVERSAMPLE);
    localparam int unsigned CNT_W = $clog2(DIV + 1);

    logic [CNT_W-1:0] cnt;

    // Down-counter, tick on terminal count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= CNT_W'(DIV - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CNT_W'(DIV - 1);
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // A divider of 1 would hold tick high and break both engines
    assert property (@(posedge clk) DIV >= 2)
        else $error("baud divider %0d below 2", DIV);

endmodule

//--- hw/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// System clock in Hz
`define UART_CLK_FREQ 1_600_000

// Line rate in bits per second
`define UART_BAUD_RATE 10_000

// Oversample ticks per bit
`define UART_OVERSAMPLE 16

// 0 none, 1 even, 2 odd
`define UART_PARITY 1

`endif

//--- hw/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        PAR_NONE = 2'd0,
        PAR_EVEN = 2'd1,
        PAR_ODD  = 2'd2
    } parity_mode_e;

    localparam parity_mode_e PARITY_MODE = parity_mode_e'(`UART_PARITY);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // Received byte plus its status
    typedef struct packed {
        logic [7:0] data;
        logic       parity_err;
        logic       frame_err;
        logic       overrun;    // Set later by the holding port
    } rx_word_t;

endpackage

//--- hw/uart_rx.sv
`include "uart_defines.svh"

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic               rxd,
    output logic               word_valid,
    output uart_pkg::rx_word_t word
);
    import uart_pkg::*;

    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [3:0] MID_LAST  = 4'(`UART_OVERSAMPLE / 2 - 1);

    rx_state_e  state;
    logic       rxd_meta;
    logic       rxd_sync;
    logic       rxd_prev;
    logic       fall;
    logic       sample;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic       par_err;

    // Two-flop synchronizer, third flop for edge detect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall   = rxd_prev && !rxd_sync;
    assign sample = tick && (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= RX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    if (tick) begin
                        if (rxd_sync) begin
                            state <= RX_IDLE;    // False start
                        end else if (tick_cnt == MID_LAST) begin
                            state    <= RX_DATA;    // Now at start bit centre
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + 4'd1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                    if (sample) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= (PARITY_MODE == PAR_NONE) ? RX_STOP : RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                    if (sample) begin
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                    if (sample) begin
                        state      <= RX_IDLE;
                        word_valid <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample && state == RX_DATA) begin
            shreg <= {rxd_sync, shreg[7:1]};    // LSB first
        end
        if (sample && state == RX_PARITY) begin
            par_err <= rxd_sync ^ ^shreg ^ (PARITY_MODE == PAR_ODD);
        end
        if (sample && state == RX_STOP) begin
            word.data       <= shreg;
            word.parity_err <= (PARITY_MODE != PAR_NONE) && par_err;
            word.frame_err  <= !rxd_sync;
            word.overrun    <= 1'b0;
        end
    end

    // Relies on the baud tick being a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) word_valid |=> !word_valid)
        else $error("word_valid high for two cycles");

endmodule

//--- hw/uart_rx_port.sv
module uart_rx_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_valid,
    input  uart_pkg::rx_word_t word,
    output logic               rx_req,
    output uart_pkg::rx_word_t rx_word,
    input  logic               rx_ack
);
    import uart_pkg::*;

    logic accept;

    // Empty only once the consumer has dropped its ack
    assign accept = word_valid && !rx_req && !rx_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_req <= 1'b0;
        end else if (rx_req && rx_ack) begin
            rx_req <= 1'b0;
        end else if (accept) begin
            rx_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rx_word <= word;
        end else if (word_valid && rx_req) begin
            rx_word.overrun <= 1'b1;    // New word lost
        end
    end

    // Payload may not move under the consumer, only overrun can appear
    assert property (@(posedge clk) disable iff (rst)
        rx_req && !rx_ack |=>
            $stable({rx_word.data, rx_word.parity_err, rx_word.frame_err}))
        else $error("rx_word changed while offered");

endmodule

//--- hw/uart_top.sv
module uart_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               tx_req,
    input  logic [7:0]         tx_data,
    output logic               tx_ack,
    output logic               rx_req,
    output uart_pkg::rx_word_t rx_word,
    input  logic               rx_ack,
    output logic               txd,
    input  logic               rxd
);
    import uart_pkg::*;

    logic       tick;
    logic       byte_valid;
    logic       byte_take;
    logic [7:0] byte_data;
    logic       word_valid;
    rx_word_t   word;

    // One tick source for both directions
    uart_baud_gen i_baud_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_tx_port i_tx_port (
        .clk        (clk),
        .rst        (rst),
        .tx_req     (tx_req),
        .tx_data    (tx_data),
        .tx_ack     (tx_ack),
        .byte_take  (byte_take),
        .byte_valid (byte_valid),
        .byte_data  (byte_data)
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_take  (byte_take),
        .txd        (txd)
    );

    uart_rx i_rx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .rxd        (rxd),
        .word_valid (word_valid),
        .word       (word)
    );

    uart_rx_port i_rx_port (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word       (word),
        .rx_req     (rx_req),
        .rx_word    (rx_word),
        .rx_ack     (rx_ack)
    );

endmodule

//--- hw/uart_tx.sv
`include "uart_defines.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       byte_take,
    output logic       txd
);
    import uart_pkg::*;

    localparam logic [3:0] TICK_LAST = 4'(`UART_OVERSAMPLE - 1);

    tx_state_e  state;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic       par_bit;
    logic       bit_end;

    assign bit_end   = tick && (tick_cnt == TICK_LAST);
    assign byte_take = bit_end && byte_valid && (state == TX_IDLE || state == TX_STOP);

    // Bit grid keeps running while idle so frames start on a boundary
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= tick_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            txd     <= 1'b1;
        end else if (bit_end) begin
            case (state)
                TX_IDLE, TX_STOP: begin
                    if (byte_valid) begin
                        state <= TX_START;
                        txd   <= 1'b0;    // Start bit
                    end else begin
                        state <= TX_IDLE;
                        txd   <= 1'b1;
                    end
                end
                TX_START: begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                    txd     <= shreg[0];
                end
                TX_DATA: begin
                    if (bit_cnt == 3'd7) begin
                        if (PARITY_MODE == PAR_NONE) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            state <= TX_PARITY;
                            txd   <= par_bit;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 3'd1;
                        txd     <= shreg[1];    // Next bit after this shift
                    end
                end
                TX_PARITY: begin
                    state <= TX_STOP;
                    txd   <= 1'b1;
                end
                default: begin
                    state <= TX_IDLE;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_take) begin
            shreg   <= byte_data;
            par_bit <= ^byte_data ^ (PARITY_MODE == PAR_ODD);
        end else if (bit_end && state == TX_DATA) begin
            shreg <= shreg >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) state == TX_IDLE |-> txd)
        else $error("txd low while transmitter idle");

endmodule

//--- hw/uart_tx_port.sv
module uart_tx_port (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_req,
    input  logic [7:0] tx_data,
    output logic       tx_ack,
    input  logic       byte_take,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    // Four-phase ack, a new request waits for an empty buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_ack <= 1'b0;
        end else if (tx_ack) begin
            if (!tx_req) begin
                tx_ack <= 1'b0;
            end
        end else if (tx_req && !byte_valid) begin
            tx_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else if (!tx_ack && tx_req && !byte_valid) begin
            byte_valid <= 1'b1;
        end else if (byte_take) begin
            byte_valid <= 1'b0;    // Transmitter has the byte
        end
    end

    always_ff @(posedge clk) begin
        if (!tx_ack && tx_req && !byte_valid) begin
            byte_data <= tx_data;
        end
    end

    // Ack answers a request seen the cycle before
    assert property (@(posedge clk) disable iff (rst) $rose(tx_ack) |-> $past(tx_req))
        else $error("tx_ack rose without tx_req");

endmodule

//--- vlog.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx_port.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_rx_port.sv
hw/uart_top.sv
bench/tb_uart_top.sv
